/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = hart_tb
FILELIST = filelist.f
BUILD    = obj_dir
PASS     = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(BUILD)

/* bench/hart_model.svh */
/*
 * reference side of the hart testbench
 * LFSR, random program generator and an ISA model that
 * produces the expected stream of register writes
 */
`ifndef HART_MODEL_SVH
`define HART_MODEL_SVH

// beq x0,x0,0
localparam logic [31:0] SELF_LOOP = 32'h0000_0063;

logic [31:0] lfsr_state;
logic [31:0] prog_mem [0:255];
logic [63:0] exp_pc_q [$];
logic [4:0]  exp_rd_q [$];
logic [63:0] exp_data_q [$];

// fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          k;
    val = '0;
    for (k = 0; k < n; k++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        val = {val[30:0], fb};
    end
    return val;
endfunction

// x0..x7 only, so dependencies come often
function automatic logic [4:0] rand_reg();
    return {2'b00, 3'(rand_bits(3))};
endfunction

function automatic void gen_program(input int body_len);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic        alt;
    logic [12:0] off;
    int          i;
    for (i = 0; i < 256; i++) begin
        prog_mem[i] = SELF_LOOP;
    end
    // lui then addi gives every readable register a known value
    for (i = 1; i < 8; i++) begin
        prog_mem[2*i-2] = {20'(rand_bits(20)), 5'(i), 7'b0110111};
        prog_mem[2*i-1] = {12'(rand_bits(12)), 5'(i), 3'b000, 5'(i), 7'b0010011};
    end
    for (i = 14; i < 14 + body_len; i++) begin
        kind = 3'(rand_bits(3));
        rd   = rand_reg();
        rs1  = rand_reg();
        rs2  = rand_reg();
        f3   = 3'(rand_bits(3));
        case (kind)
            3'd0, 3'd1: begin
                // sub and sra are the funct7 variants
                alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rand_bits(1)) : 1'b0;
                prog_mem[i] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
            end
            3'd2, 3'd3: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    alt = (f3 == 3'd5) ? 1'(rand_bits(1)) : 1'b0;
                    prog_mem[i] = {1'b0, alt, 4'b0, 6'(rand_bits(6)), rs1, f3, rd,
                                   7'b0010011};
                end else begin
                    prog_mem[i] = {12'(rand_bits(12)), rs1, f3, rd, 7'b0010011};
                end
            end
            3'd4: prog_mem[i] = {20'(rand_bits(20)), rd, 7'b0110111};
            3'd5: prog_mem[i] = {20'(rand_bits(20)), rd, 7'b0010111};
            default: begin
                // forward only, equal operands half the time
                off = (rand_bits(1) != 0) ? 13'd12 : 13'd8;
                if (rand_bits(1) != 0) begin
                    rs2 = rs1;
                end
                prog_mem[i] = {off[12], off[10:5], rs2, rs1, 2'b00, f3[0], off[4:1],
                               off[11], 7'b1100011};
            end
        endcase
    end
endfunction

function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [63:0] a, input logic [63:0] b);
    case (f3)
        3'd0: alu_ref = alt ? a - b : a + b;
        3'd1: alu_ref = a << b[5:0];
        3'd2: alu_ref = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'd3: alu_ref = (a < b) ? 64'd1 : 64'd0;
        3'd4: alu_ref = a ^ b;
        3'd5: begin
            if (alt) begin
                alu_ref = $signed(a) >>> b[5:0];
            end else begin
                alu_ref = a >> b[5:0];
            end
        end
        3'd6: alu_ref = a | b;
        default: alu_ref = a & b;
    endcase
endfunction

// runs prog_mem from pc 0 up to the self-loop, returns the write count
function automatic int run_model();
    logic [63:0] x [0:31];
    logic [63:0] pc;
    logic [63:0] next_pc;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] res;
    logic [31:0] ir;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wr;
    int          n;
    int          steps;
    int          i;
    for (i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    exp_pc_q.delete();
    exp_rd_q.delete();
    exp_data_q.delete();
    pc    = '0;
    n     = 0;
    steps = 0;
    ir    = prog_mem[pc[9:2]];
    while (ir != SELF_LOOP && steps < 1000) begin
        rd      = ir[11:7];
        f3      = ir[14:12];
        imm_i   = {{52{ir[31]}}, ir[31:20]};
        imm_u   = {{32{ir[31]}}, ir[31:12], 12'h000};
        next_pc = pc + 64'd4;
        wr      = 1'b1;
        res     = '0;
        case (ir[6:0])
            7'b0110011: res = alu_ref(f3, ir[30], x[ir[19:15]], x[ir[24:20]]);
            7'b0010011: res = alu_ref(f3, f3 == 3'd5 && ir[30], x[ir[19:15]], imm_i);
            7'b0110111: res = imm_u;
            7'b0010111: res = pc + imm_u;
            default: begin
                wr = 1'b0;
                if ((f3 == 3'd0 && x[ir[19:15]] == x[ir[24:20]]) ||
                    (f3 == 3'd1 && x[ir[19:15]] != x[ir[24:20]])) begin
                    next_pc = pc + {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
                end
            end
        endcase
        if (wr && rd != 5'd0) begin
            x[rd] = res;
            exp_pc_q.push_back(pc);
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
            n++;
        end
        pc = next_pc;
        ir = prog_mem[pc[9:2]];
        steps++;
    end
    return n;
endfunction

`endif

/* bench/hart_tb.sv */
/*
 * testbench for the reduced RV64 hart
 * random ALU, upper-immediate and branch programs,
 * retire stream checked against the ISA model
 */
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module hart_tb;

    localparam int NUM_PROGS = 24;
    localparam int BODY_LEN  = 48;
    localparam int TIMEOUT   = 1000;

    logic                h_clk;
    logic                h_rst_n;
    logic                ld_wr_i;
    logic [`IMEM_AW-1:0] ld_addr_i;
    logic [31:0]         ld_data_i;
    logic                start_i;
    logic                ret_valid_o;
    logic [4:0]          ret_rd_o;
    logic [`XLEN-1:0]    ret_data_o;
    logic [`XLEN-1:0]    ret_pc_o;
    logic [31:0]         ret_count_o;

    int retire_errs;
    int check_errs;
    int exp_count;

    `include "hart_model.svh"

    hart uut (
        .h_clk       (h_clk),
        .h_rst_n     (h_rst_n),
        .ld_wr_i     (ld_wr_i),
        .ld_addr_i   (ld_addr_i),
        .ld_data_i   (ld_data_i),
        .start_i     (start_i),
        .ret_valid_o (ret_valid_o),
        .ret_rd_o    (ret_rd_o),
        .ret_data_o  (ret_data_o),
        .ret_pc_o    (ret_pc_o),
        .ret_count_o (ret_count_o)
    );

    always #5 h_clk = ~h_clk;

    // retire outputs come from registers, stable at the falling edge
    always @(negedge h_clk) begin : compare_retire
        logic [63:0] e_pc;
        logic [4:0]  e_rd;
        logic [63:0] e_data;
        if (ret_valid_o) begin
            assert (exp_pc_q.size() > 0) else begin
                retire_errs++;
                $display("unexpected retire of x%0d at pc %h, time %0t", ret_rd_o,
                         ret_pc_o, $time);
            end
            if (exp_pc_q.size() > 0) begin
                e_pc   = exp_pc_q.pop_front();
                e_rd   = exp_rd_q.pop_front();
                e_data = exp_data_q.pop_front();
                assert (ret_pc_o == e_pc) else begin
                    retire_errs++;
                    $display("** Error at %0t: ret_pc_o expected %h, got %h", $time,
                             e_pc, ret_pc_o);
                end
                assert (ret_rd_o == e_rd) else begin
                    retire_errs++;
                    $display("** Error at %0t: ret_rd_o expected %0d, got %0d", $time,
                             e_rd, ret_rd_o);
                end
                assert (ret_data_o == e_data) else begin
                    retire_errs++;
                    $display("** Error at %0t: ret_data_o expected %h, got %h", $time,
                             e_data, ret_data_o);
                end
            end
        end
    end

    task automatic reset_hart();
        @(negedge h_clk);
        h_rst_n = 1'b0;
        repeat (3) @(negedge h_clk);
        h_rst_n = 1'b1;
    endtask

    // nothing may retire before start
    task automatic check_idle();
        repeat (20) begin
            @(negedge h_clk);
            assert (ret_valid_o == 1'b0) else begin
                check_errs++;
                $display("** Error at %0t: ret_valid_o expected 0, got %b", $time,
                         ret_valid_o);
            end
            assert (ret_count_o == 32'd0) else begin
                check_errs++;
                $display("** Error at %0t: ret_count_o expected 0, got %0d", $time,
                         ret_count_o);
            end
        end
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < 256; i++) begin
            @(negedge h_clk);
            ld_wr_i   = 1'b1;
            ld_addr_i = `IMEM_AW'(i);
            ld_data_i = prog_mem[i];
        end
        @(negedge h_clk);
        ld_wr_i = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge h_clk);
        start_i = 1'b1;
        @(negedge h_clk);
        start_i = 1'b0;
    endtask

    task automatic wait_retired();
        int cycles;
        cycles = 0;
        while (exp_pc_q.size() > 0 && cycles < TIMEOUT) begin
            @(negedge h_clk);
            cycles++;
        end
        assert (exp_pc_q.size() == 0) else begin
            check_errs++;
            $display("timed out with %0d expected writes not retired, time %0t",
                     exp_pc_q.size(), $time);
        end
        cycles = 0;
        while (ret_count_o != 32'(exp_count) && cycles < TIMEOUT) begin
            @(negedge h_clk);
            cycles++;
        end
        // program sits in its self-loop, any further retire is an error
        repeat (8) @(negedge h_clk);
        assert (ret_count_o == 32'(exp_count)) else begin
            check_errs++;
            $display("** Error at %0t: ret_count_o expected %0d, got %0d", $time,
                     exp_count, ret_count_o);
        end
    endtask

    initial begin
        int p;
        h_clk       = 1'b0;
        h_rst_n     = 1'b0;
        ld_wr_i     = 1'b0;
        ld_addr_i   = '0;
        ld_data_i   = '0;
        start_i     = 1'b0;
        retire_errs = 0;
        check_errs  = 0;
        exp_count   = 0;
        lfsr_state  = 32'h90f7;
        for (p = 0; p < NUM_PROGS; p++) begin
            reset_hart();
            check_idle();
            gen_program(BODY_LEN);
            exp_count = run_model();
            load_program();
            pulse_start();
            wait_retired();
        end
        $display("errors: %0d on the retire port, %0d in other checks", retire_errs,
                 check_errs);
        if (retire_errs == 0 && check_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/decode_unit.sv */
/*
 * decode unit
 * field split, immediate format mux, operand bypass from
 * execute and writeback, branch resolution and redirect,
 * and operand selection for the execute stage
 */
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module decode_unit import hart_pkg::*; (
    input  wire logic             h_clk,
    input  fd_t                   fd_i,
    input  wire logic             ex_wr_i,
    input  wire logic [4:0]       ex_rd_i,
    input  wire logic [`XLEN-1:0] ex_data_i,
    wb_bus                        wb,
    output dx_t                   dx_o,
    output logic                  redirect_o,
    output logic      [`XLEN-1:0] target_o
);

    logic [4:0]       rs1, rs2, rd;
    logic [2:0]       funct3;
    opcode_e          opcode;
    logic [`XLEN-1:0] imm_i, imm_u, imm_b, imm;
    logic [`XLEN-1:0] r1_rf, r2_rf, r1, r2;
    logic             ex_hit1, ex_hit2;
    logic             eq;
    alu_op_e          alu_op;
    logic             use_pc, zero_a, use_imm, writes;

    // shared by OP and OP-IMM, sub only exists for OP
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic f7_5,
                                        input logic reg_op);
        case (f3)
            3'b000:  alu_sel = (reg_op && f7_5) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = f7_5 ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(fd_i.ir[6:0]);
    assign rd     = fd_i.ir[11:7];
    assign funct3 = fd_i.ir[14:12];
    assign rs1    = fd_i.ir[19:15];
    assign rs2    = fd_i.ir[24:20];

    assign imm_i = {{52{fd_i.ir[31]}}, fd_i.ir[31:20]};
    assign imm_u = {{32{fd_i.ir[31]}}, fd_i.ir[31:12], 12'b0};
    assign imm_b = {{51{fd_i.ir[31]}}, fd_i.ir[31], fd_i.ir[7],
                    fd_i.ir[30:25], fd_i.ir[11:8], 1'b0};

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm = imm_u;
            OPC_BRANCH:         imm = imm_b;
            default:            imm = imm_i;
        endcase
    end

    regfile u_regfile (
        .h_clk (h_clk),
        .rs1_i (rs1),
        .rs2_i (rs2),
        .r1_o  (r1_rf),
        .r2_o  (r2_rf),
        .wb    (wb)
    );

    // execute result wins, the file already returns a same-cycle writeback
    assign ex_hit1 = ex_wr_i && ex_rd_i == rs1 && rs1 != 5'd0;
    assign ex_hit2 = ex_wr_i && ex_rd_i == rs2 && rs2 != 5'd0;

    assign r1 = ex_hit1 ? ex_data_i : r1_rf;
    assign r2 = ex_hit2 ? ex_data_i : r2_rf;

    // beq and bne only
    assign eq         = (r1 == r2);
    assign redirect_o = fd_i.valid && opcode == OPC_BRANCH &&
                        ((funct3 == 3'b000 && eq) || (funct3 == 3'b001 && !eq));
    assign target_o   = fd_i.pc + imm;

    always_comb begin
        alu_op  = ALU_ADD;
        use_pc  = 1'b0;
        zero_a  = 1'b0;
        use_imm = 1'b1;
        writes  = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op  = alu_sel(funct3, fd_i.ir[30], 1'b1);
                use_imm = 1'b0;
                writes  = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op = alu_sel(funct3, fd_i.ir[30], 1'b0);
                writes = 1'b1;
            end
            OPC_LUI: begin
                alu_op = ALU_PASS_B;
                zero_a = 1'b1;
                writes = 1'b1;
            end
            OPC_AUIPC: begin
                use_pc = 1'b1;
                writes = 1'b1;
            end
            default: begin
                // branches and unknown opcodes write nothing
                writes = 1'b0;
            end
        endcase
    end

    assign dx_o.pc     = fd_i.pc;
    assign dx_o.a      = use_pc ? fd_i.pc : (zero_a ? '0 : r1);
    assign dx_o.b      = use_imm ? imm : r2;
    assign dx_o.alu_op = alu_op;
    assign dx_o.rd     = rd;
    assign dx_o.wr     = writes && fd_i.valid;
    assign dx_o.valid  = fd_i.valid;

endmodule

`default_nettype wire

/* design/exec_unit.sv */
/*
 * execute unit
 * 64-bit ALU on the operands chosen in decode,
 * result also returned to decode for bypass
 */
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module exec_unit import hart_pkg::*; (
    input  dx_t                   dx_i,
    output xw_t                   xw_o,
    output logic                  ex_wr_o,
    output logic      [4:0]       ex_rd_o,
    output logic      [`XLEN-1:0] ex_data_o
);

    logic [`XLEN-1:0] a, b, result;
    logic [5:0]       shamt;

    assign a     = dx_i.a;
    assign b     = dx_i.b;
    // RV64 shifts use six bits
    assign shamt = b[5:0];

    always_comb begin
        case (dx_i.alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {63'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {63'b0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    assign xw_o.rd    = dx_i.rd;
    assign xw_o.data  = result;
    assign xw_o.pc    = dx_i.pc;
    assign xw_o.wr    = dx_i.wr;
    assign xw_o.valid = dx_i.valid;

    // bypass to decode
    assign ex_wr_o   = dx_i.valid && dx_i.wr;
    assign ex_rd_o   = dx_i.rd;
    assign ex_data_o = result;

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
/*
 * fetch unit
 * program counter with branch redirect, local instruction
 * memory with a load port, idle until started
 */
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module fetch_unit import hart_pkg::*; (
    input  wire logic               h_clk,
    input  wire logic               h_rst_n,
    input  wire logic               start_i,
    input  wire logic               ld_wr_i,
    input  wire logic [`IMEM_AW-1:0] ld_addr_i,
    input  wire logic [31:0]        ld_data_i,
    input  wire logic               redirect_i,
    input  wire logic [`XLEN-1:0]   target_i,
    output fd_t                     fd_o
);

    logic [31:0]      imem [0:(1 << `IMEM_AW)-1];
    logic [31:0]      ir;
    logic [`XLEN-1:0] pc;
    logic             running;

    // load port, usable at any time
    always_ff @(posedge h_clk) begin
        if (ld_wr_i) begin
            imem[ld_addr_i] <= ld_data_i;
        end
    end

    always_ff @(posedge h_clk) begin
        if (!h_rst_n) begin
            running <= 1'b0;
            pc      <= '0;
        end else if (!running) begin
            if (start_i) begin
                running <= 1'b1;
                pc      <= '0;
            end
        end else if (redirect_i) begin
            pc <= target_i;
        end else begin
            pc <= pc + `XLEN'd4;
        end
    end

    // word addressed, asynchronous read
    assign ir = imem[pc[`IMEM_AW+1:2]];

    assign fd_o.pc    = pc;
    assign fd_o.ir    = running ? ir : `INS_NOP;
    assign fd_o.valid = running;

endmodule

`default_nettype wire

/* design/hart.sv */
/*
 * reduced RV64 hart, top level
 * four stages: fetch, decode, execute, writeback
 * branches resolve in decode, full operand bypass, no stalls
 */
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module hart import hart_pkg::*; (
    input  wire logic                h_clk,
    input  wire logic                h_rst_n,
    input  wire logic                ld_wr_i,
    input  wire logic [`IMEM_AW-1:0] ld_addr_i,
    input  wire logic [31:0]         ld_data_i,
    input  wire logic                start_i,
    output logic                     ret_valid_o,
    output logic      [4:0]          ret_rd_o,
    output logic      [`XLEN-1:0]    ret_data_o,
    output logic      [`XLEN-1:0]    ret_pc_o,
    output logic      [31:0]         ret_count_o
);

    fd_t              fd_d, fd_q;
    dx_t              dx_d, dx_q;
    xw_t              xw_d;
    logic             redirect;
    logic [`XLEN-1:0] target;
    logic             ex_wr;
    logic [4:0]       ex_rd;
    logic [`XLEN-1:0] ex_data;

    wb_bus wb_if ();

    fetch_unit u_fetch (
        .h_clk      (h_clk),
        .h_rst_n    (h_rst_n),
        .start_i    (start_i),
        .ld_wr_i    (ld_wr_i),
        .ld_addr_i  (ld_addr_i),
        .ld_data_i  (ld_data_i),
        .redirect_i (redirect),
        .target_i   (target),
        .fd_o       (fd_d)
    );

    // wrong-path fetch is dropped when a branch is taken
    stage_reg #(
        .payload_t (fd_t),
        .BUBBLE    (FD_BUBBLE),
        .CTRL_MASK (FD_CTRL)
    ) u_fd_reg (
        .h_clk   (h_clk),
        .h_rst_n (h_rst_n),
        .flush_i (redirect),
        .d_i     (fd_d),
        .q_o     (fd_q)
    );

    decode_unit u_decode (
        .h_clk      (h_clk),
        .fd_i       (fd_q),
        .ex_wr_i    (ex_wr),
        .ex_rd_i    (ex_rd),
        .ex_data_i  (ex_data),
        .wb         (wb_if),
        .dx_o       (dx_d),
        .redirect_o (redirect),
        .target_o   (target)
    );

    stage_reg #(
        .payload_t (dx_t),
        .BUBBLE    (DX_BUBBLE),
        .CTRL_MASK (DX_CTRL)
    ) u_dx_reg (
        .h_clk   (h_clk),
        .h_rst_n (h_rst_n),
        .flush_i (1'b0),
        .d_i     (dx_d),
        .q_o     (dx_q)
    );

    exec_unit u_exec (
        .dx_i      (dx_q),
        .xw_o      (xw_d),
        .ex_wr_o   (ex_wr),
        .ex_rd_o   (ex_rd),
        .ex_data_o (ex_data)
    );

    retire_unit u_retire (
        .h_clk       (h_clk),
        .h_rst_n     (h_rst_n),
        .xw_i        (xw_d),
        .wb          (wb_if.source),
        .ret_valid_o (ret_valid_o),
        .ret_rd_o    (ret_rd_o),
        .ret_data_o  (ret_data_o),
        .ret_pc_o    (ret_pc_o),
        .ret_count_o (ret_count_o)
    );

endmodule

`default_nettype wire

/* design/hart_defs.svh */
/*
 * reduced RV64 hart, global widths and constants
 * shared by the package and the RTL modules
 */
`ifndef HART_DEFS_SVH
`define HART_DEFS_SVH

// integer register and datapath width
`define XLEN 64

// instruction memory word address width, 256 words
`define IMEM_AW 8

// bubble instruction, addi x0,x0,0
`define INS_NOP 32'h13

`endif

/* design/hart_pkg.sv */
/*
 * hart package
 * major opcodes, ALU operations and the payloads carried
 * between the pipeline stages, with their bubble values
 */
`default_nettype none

`include "hart_defs.svh"

package hart_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // fetch to decode
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      ir;
        logic             valid;
    } fd_t;

    // decode to execute, operands already selected
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        alu_op_e          alu_op;
        logic [4:0]       rd;
        logic             wr;
        logic             valid;
    } dx_t;

    // execute to writeback
    typedef struct packed {
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
        logic [`XLEN-1:0] pc;
        logic             wr;
        logic             valid;
    } xw_t;

    // bubble contents and the control bits they apply to
    localparam fd_t FD_BUBBLE = '{pc: '0, ir: `INS_NOP, valid: 1'b0};
    localparam fd_t FD_CTRL   = '{pc: '0, ir: '1, valid: 1'b1};

    localparam dx_t DX_BUBBLE = '{pc: '0, a: '0, b: '0, alu_op: ALU_ADD,
                                  rd: '0, wr: 1'b0, valid: 1'b0};
    localparam dx_t DX_CTRL   = '{pc: '0, a: '0, b: '0, alu_op: alu_op_e'(4'hf),
                                  rd: '1, wr: 1'b1, valid: 1'b1};

    localparam xw_t XW_BUBBLE = '{rd: '0, data: '0, pc: '0, wr: 1'b0, valid: 1'b0};
    localparam xw_t XW_CTRL   = '{rd: '1, data: '0, pc: '0, wr: 1'b1, valid: 1'b1};

endpackage

`default_nettype wire

/* design/regfile.sv */
/*
 * integer register file, 32 x XLEN
 * two asynchronous read ports, one write port from the
 * writeback bus, write-first, x0 hardwired to zero
 */
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module regfile (
    input  wire logic             h_clk,
    input  wire logic [4:0]       rs1_i,
    input  wire logic [4:0]       rs2_i,
    output logic      [`XLEN-1:0] r1_o,
    output logic      [`XLEN-1:0] r2_o,
    wb_bus.sink                   wb
);

    logic [`XLEN-1:0] regs [0:31];

    always_ff @(posedge h_clk) begin
        if (wb.wr && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is visible to the reader
    assign r1_o = (rs1_i == 5'd0)               ? '0      :
                  (wb.wr && wb.rd == rs1_i)     ? wb.data : regs[rs1_i];
    assign r2_o = (rs2_i == 5'd0)               ? '0      :
                  (wb.wr && wb.rd == rs2_i)     ? wb.data : regs[rs2_i];

endmodule

`default_nettype wire

/* design/retire_unit.sv */
/*
 * retire unit
 * execute/writeback register, drives the writeback bus,
 * reports retired writes and counts them
 */
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module retire_unit import hart_pkg::*; (
    input  wire logic             h_clk,
    input  wire logic             h_rst_n,
    input  xw_t                   xw_i,
    wb_bus.source                 wb,
    output logic                  ret_valid_o,
    output logic      [4:0]       ret_rd_o,
    output logic      [`XLEN-1:0] ret_data_o,
    output logic      [`XLEN-1:0] ret_pc_o,
    output logic      [31:0]      ret_count_o
);

    xw_t xw_q;

    stage_reg #(
        .payload_t (xw_t),
        .BUBBLE    (XW_BUBBLE),
        .CTRL_MASK (XW_CTRL)
    ) u_xw_reg (
        .h_clk   (h_clk),
        .h_rst_n (h_rst_n),
        .flush_i (1'b0),
        .d_i     (xw_i),
        .q_o     (xw_q)
    );

    assign wb.wr   = xw_q.valid && xw_q.wr;
    assign wb.rd   = xw_q.rd;
    assign wb.data = xw_q.data;
    assign wb.pc   = xw_q.pc;

    // retire port mirrors the bus, x0 writes are not reported
    assign ret_valid_o = wb.wr && wb.rd != 5'd0;
    assign ret_rd_o    = wb.rd;
    assign ret_data_o  = wb.data;
    assign ret_pc_o    = wb.pc;

    always_ff @(posedge h_clk) begin
        if (!h_rst_n) begin
            ret_count_o <= '0;
        end else if (ret_valid_o) begin
            ret_count_o <= ret_count_o + 32'd1;
        end
    end

endmodule

`default_nettype wire

/* design/stage_reg.sv */
/*
 * pipeline stage register
 * loads every cycle, on reset or flush the control bits
 * take the bubble value while data bits keep following d_i
 */
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type      payload_t = logic,
    parameter payload_t BUBBLE    = '0,
    parameter payload_t CTRL_MASK = '0
) (
    input  wire logic h_clk,
    input  wire logic h_rst_n,
    input  wire logic flush_i,
    input  payload_t  d_i,
    output payload_t  q_o
);

    always_ff @(posedge h_clk) begin
        if (!h_rst_n || flush_i) begin
            // only the bits under CTRL_MASK are forced
            q_o <= payload_t'((d_i & ~CTRL_MASK) | (BUBBLE & CTRL_MASK));
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* design/wb_bus.sv */
/*
 * writeback bus
 * one register write per cycle from the retire unit,
 * taken by the register file and the decode bypass
 */
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

interface wb_bus;

    logic             wr;
    logic [4:0]       rd;
    logic [`XLEN-1:0] data;
    logic [`XLEN-1:0] pc;

    modport source  (output wr, rd, data, pc);
    modport sink    (input  wr, rd, data);
    // observing view, same signals as the write port
    modport monitor (input  wr, rd, data, pc);

endinterface

`default_nettype wire

/* filelist.f */
+incdir+design
+incdir+bench
design/hart_pkg.sv
design/wb_bus.sv
design/stage_reg.sv
design/fetch_unit.sv
design/regfile.sv
design/decode_unit.sv
design/exec_unit.sv
design/retire_unit.sv
design/hart.sv
bench/hart_tb.sv
